/* loader_pkg.sv */
`default_nettype none

package loader_pkg;

    // Command opcode in the top two bits of a header byte
    typedef enum logic [1:0] {
        OP_LOAD     = 2'd0,
        OP_SET_ADDR = 2'd1,
        OP_READ     = 2'd2,
        OP_SUM      = 2'd3
    } loader_op_e;

    // Header byte layout
    // count holds length minus one, so 1 to 64 bytes
    typedef struct packed {
        loader_op_e op;
        logic [5:0] count;
    } loader_hdr_t;

    // Received byte
    // Decoded as a header while idle, as raw data for operands
    typedef union packed {
        loader_hdr_t hdr;
        logic [7:0]  raw;
    } loader_byte_u;

    // Kind of byte on the response port
    typedef enum logic {
        RESP_READ = 1'b0,
        RESP_SUM  = 1'b1
    } resp_kind_e;

endpackage

`default_nettype wire

/* rom_loader_decode.sv */
`default_nettype none

module rom_loader_decode #(
    parameter int ROM_ADDR_W = 14
) (
    input  logic                     rx_ready,
    input  logic                     i_rst_n,
    input  logic                     i_byte_valid,
    input  loader_pkg::loader_byte_u i_byte,
    output logic                     o_byte_ready,
    output logic                     o_op_valid,
    output loader_pkg::loader_op_e   o_op_kind,
    output logic                     o_op_addr_load,
    output logic [ROM_ADDR_W-1:0]    o_op_addr,
    output logic [7:0]               o_op_data,
    input  logic                     i_op_ready,
    output logic                     o_sum_valid,
    input  logic                     i_sum_ready
);

    import loader_pkg::*;

    // Parser states
    localparam logic [2:0] S_HDR     = 3'd0;
    localparam logic [2:0] S_ADDR_HI = 3'd1;
    localparam logic [2:0] S_ADDR_LO = 3'd2;
    localparam logic [2:0] S_DATA    = 3'd3;
    localparam logic [2:0] S_READ    = 3'd4;
    localparam logic [2:0] S_SUM     = 3'd5;

    logic [2:0]  state;
    // Bytes or reads left, minus one
    logic [5:0]  len;
    logic [7:0]  addr_hi;
    logic [15:0] addr_word;
    logic        slot_free;
    logic        byte_fire;
    logic        op_fire;

    // Pending op register can take a new op this edge
    assign slot_free = !o_op_valid || i_op_ready;
    assign op_fire   = o_op_valid && i_op_ready;

    // Header and high address byte never issue an op
    // Low address and data bytes need the op slot
    assign o_byte_ready = (state == S_HDR) || (state == S_ADDR_HI) ||
                          (((state == S_ADDR_LO) || (state == S_DATA)) && slot_free);
    assign byte_fire    = i_byte_valid && o_byte_ready;

    // Report only once every earlier write has been counted
    assign o_sum_valid = (state == S_SUM) && !o_op_valid;

    // Full 16-bit address, cut down to the ROM width below
    assign addr_word = {addr_hi, i_byte.raw};

    always_ff @(posedge rx_ready) begin
        if (!i_rst_n) begin
            state      <= S_HDR;
            len        <= 6'd0;
            o_op_valid <= 1'b0;
        end else begin
            if (op_fire) begin
                o_op_valid <= 1'b0;
            end
            case (state)
                S_HDR: begin
                    if (byte_fire) begin
                        len <= i_byte.hdr.count;
                        case (i_byte.hdr.op)
                            OP_LOAD:     state <= S_DATA;
                            OP_SET_ADDR: state <= S_ADDR_HI;
                            OP_READ:     state <= S_READ;
                            OP_SUM:      state <= S_SUM;
                        endcase
                    end
                end
                S_ADDR_HI: begin
                    if (byte_fire) begin
                        state <= S_ADDR_LO;
                    end
                end
                S_ADDR_LO: begin
                    if (byte_fire) begin
                        o_op_valid <= 1'b1;
                        state      <= S_HDR;
                    end
                end
                S_DATA: begin
                    // One write per operand byte
                    if (byte_fire) begin
                        o_op_valid <= 1'b1;
                        if (len == 6'd0) begin
                            state <= S_HDR;
                        end else begin
                            len <= len - 6'd1;
                        end
                    end
                end
                S_READ: begin
                    // Reads are issued without taking bytes
                    if (slot_free) begin
                        o_op_valid <= 1'b1;
                        if (len == 6'd0) begin
                            state <= S_HDR;
                        end else begin
                            len <= len - 6'd1;
                        end
                    end
                end
                S_SUM: begin
                    if (o_sum_valid && i_sum_ready) begin
                        state <= S_HDR;
                    end
                end
                default: state <= S_HDR;
            endcase
        end
    end

    // Op payload and the saved high address byte
    always_ff @(posedge rx_ready) begin
        if ((state == S_ADDR_HI) && byte_fire) begin
            addr_hi <= i_byte.raw;
        end
        if ((state == S_ADDR_LO) && byte_fire) begin
            o_op_kind      <= OP_SET_ADDR;
            o_op_addr_load <= 1'b1;
            o_op_addr      <= addr_word[ROM_ADDR_W-1:0];
        end else if ((state == S_DATA) && byte_fire) begin
            o_op_kind      <= OP_LOAD;
            o_op_addr_load <= 1'b0;
            o_op_data      <= i_byte.raw;
        end else if ((state == S_READ) && slot_free) begin
            o_op_kind      <= OP_READ;
            o_op_addr_load <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rom_loader_execute.sv */
`default_nettype none

module rom_loader_execute #(
    parameter int ROM_ADDR_W = 14
) (
    input  logic                   rx_ready,
    input  logic                   i_rst_n,
    input  logic                   i_op_valid,
    input  loader_pkg::loader_op_e i_op_kind,
    input  logic                   i_op_addr_load,
    input  logic [ROM_ADDR_W-1:0]  i_op_addr,
    input  logic [7:0]             i_op_data,
    output logic                   o_op_ready,
    output logic                   o_wr_fire,
    output logic [7:0]             o_wr_data,
    output logic                   o_rd_valid,
    output logic [7:0]             o_rd_data,
    input  logic                   i_rd_ready
);

    import loader_pkg::*;

    localparam int ROM_DEPTH = 1 << ROM_ADDR_W;

    // Boot ROM contents
    logic [7:0]            rom [0:ROM_DEPTH-1];
    // Auto-incrementing load/read pointer
    logic [ROM_ADDR_W-1:0] ptr;
    logic                  is_read;
    logic                  is_write;
    logic                  op_fire;

    assign is_read  = !i_op_addr_load && (i_op_kind == OP_READ);
    assign is_write = !i_op_addr_load && (i_op_kind == OP_LOAD);

    // A read waits until the read-data register is free or draining
    // Address and write ops always go through
    assign o_op_ready = !is_read || !o_rd_valid || i_rd_ready;
    assign op_fire    = i_op_valid && o_op_ready;

    // Written bytes feed the checksum on the accept edge
    assign o_wr_fire = op_fire && is_write;
    assign o_wr_data = i_op_data;

    // Array port, write and read at the pointer
    always_ff @(posedge rx_ready) begin
        if (op_fire && is_write) begin
            rom[ptr] <= i_op_data;
        end
        if (op_fire && is_read) begin
            o_rd_data <= rom[ptr];
        end
    end

    always_ff @(posedge rx_ready) begin
        if (!i_rst_n) begin
            ptr        <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            // Read data leaves once result takes it
            if (o_rd_valid && i_rd_ready) begin
                o_rd_valid <= 1'b0;
            end
            if (op_fire) begin
                if (i_op_addr_load) begin
                    ptr <= i_op_addr;
                end else if (is_read || is_write) begin
                    // Wraps at the ROM size by width
                    ptr <= ptr + 1'b1;
                end
                if (is_read) begin
                    o_rd_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rom_loader_result.sv */
`default_nettype none

module rom_loader_result (
    input  logic                   rx_ready,
    input  logic                   i_rst_n,
    input  logic                   i_wr_fire,
    input  logic [7:0]             i_wr_data,
    input  logic                   i_rd_valid,
    input  logic [7:0]             i_rd_data,
    output logic                   o_rd_ready,
    input  logic                   i_sum_valid,
    output logic                   o_sum_ready,
    output logic                   o_resp_valid,
    output loader_pkg::resp_kind_e o_resp_kind,
    output logic [7:0]             o_resp_data,
    input  logic                   i_resp_ready
);

    import loader_pkg::*;

    // Running checksum of written bytes, mod 256
    logic [7:0] sum;
    logic       slot_free;
    logic       rd_fire;
    logic       sum_fire;

    // Response register empty or emptied this edge
    assign slot_free = !o_resp_valid || i_resp_ready;

    // Read data goes first so a SUM never overtakes an older read
    assign o_rd_ready  = slot_free;
    assign o_sum_ready = slot_free && !i_rd_valid;

    assign rd_fire  = i_rd_valid && o_rd_ready;
    assign sum_fire = i_sum_valid && o_sum_ready;

    always_ff @(posedge rx_ready) begin
        if (!i_rst_n) begin
            sum          <= 8'd0;
            o_resp_valid <= 1'b0;
        end else begin
            // A write on the SUM edge starts the new sum
            if (sum_fire) begin
                sum <= i_wr_fire ? i_wr_data : 8'd0;
            end else if (i_wr_fire) begin
                sum <= sum + i_wr_data;
            end
            if (rd_fire || sum_fire) begin
                o_resp_valid <= 1'b1;
            end else if (o_resp_valid && i_resp_ready) begin
                o_resp_valid <= 1'b0;
            end
        end
    end

    // Response payload
    always_ff @(posedge rx_ready) begin
        if (rd_fire) begin
            o_resp_kind <= RESP_READ;
            o_resp_data <= i_rd_data;
        end else if (sum_fire) begin
            o_resp_kind <= RESP_SUM;
            o_resp_data <= sum;
        end
    end

endmodule

`default_nettype wire

/* rom_loader_top.sv */
`default_nettype none

module rom_loader_top #(
    // 14 bits gives the 16 KB boot ROM
    parameter int ROM_ADDR_W = 14
) (
    input  logic                   rx_ready,
    input  logic                   i_rst_n,
    input  logic                   i_byte_valid,
    input  logic [7:0]             i_byte,
    output logic                   o_byte_ready,
    output logic                   o_resp_valid,
    output loader_pkg::resp_kind_e o_resp_kind,
    output logic [7:0]             o_resp_data,
    input  logic                   i_resp_ready
);

    import loader_pkg::*;

    // Decode to execute
    logic                  op_valid;
    loader_op_e            op_kind;
    logic                  op_addr_load;
    logic [ROM_ADDR_W-1:0] op_addr;
    logic [7:0]            op_data;
    logic                  op_ready;

    // Execute to result
    logic                  wr_fire;
    logic [7:0]            wr_data;
    logic                  rd_valid;
    logic [7:0]            rd_data;
    logic                  rd_ready;

    // Decode to result
    logic                  sum_valid;
    logic                  sum_ready;

    // Command parser
    rom_loader_decode #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) rom_loader_decode_i (
        .rx_ready       (rx_ready),
        .i_rst_n        (i_rst_n),
        .i_byte_valid   (i_byte_valid),
        .i_byte         (i_byte),
        .o_byte_ready   (o_byte_ready),
        .o_op_valid     (op_valid),
        .o_op_kind      (op_kind),
        .o_op_addr_load (op_addr_load),
        .o_op_addr      (op_addr),
        .o_op_data      (op_data),
        .i_op_ready     (op_ready),
        .o_sum_valid    (sum_valid),
        .i_sum_ready    (sum_ready)
    );

    // ROM array and pointer
    rom_loader_execute #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) rom_loader_execute_i (
        .rx_ready       (rx_ready),
        .i_rst_n        (i_rst_n),
        .i_op_valid     (op_valid),
        .i_op_kind      (op_kind),
        .i_op_addr_load (op_addr_load),
        .i_op_addr      (op_addr),
        .i_op_data      (op_data),
        .o_op_ready     (op_ready),
        .o_wr_fire      (wr_fire),
        .o_wr_data      (wr_data),
        .o_rd_valid     (rd_valid),
        .o_rd_data      (rd_data),
        .i_rd_ready     (rd_ready)
    );

    // Checksum and response register
    rom_loader_result rom_loader_result_i (
        .rx_ready     (rx_ready),
        .i_rst_n      (i_rst_n),
        .i_wr_fire    (wr_fire),
        .i_wr_data    (wr_data),
        .i_rd_valid   (rd_valid),
        .i_rd_data    (rd_data),
        .o_rd_ready   (rd_ready),
        .i_sum_valid  (sum_valid),
        .o_sum_ready  (sum_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_kind  (o_resp_kind),
        .o_resp_data  (o_resp_data),
        .i_resp_ready (i_resp_ready)
    );

endmodule

`default_nettype wire

/* rom_loader_tb.sv */
`default_nettype none

module rom_loader_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import loader_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 8;
    localparam int ROM_ADDR_W      = 14;
    // Watchdog budget per byte and per expected response
    localparam int CYCLES_PER_ITEM = 40;

    logic       rx_ready;
    logic       i_rst_n;
    logic       i_byte_valid;
    logic [7:0] i_byte;
    logic       i_resp_ready;
    logic       o_byte_ready;
    logic       o_resp_valid;
    resp_kind_e o_resp_kind;
    logic [7:0] o_resp_data;

    // Stimulus file contents
    logic [7:0] byte_q[$];
    resp_kind_e exp_kind_q[$];
    logic [7:0] exp_data_q[$];
    string      test_names[$];
    int         test_bytes[$];
    int         test_exps[$];

    // Progress counters advanced on the rising edge
    int          sent_cnt   = 0;
    int          resp_cnt   = 0;
    int          byte_limit = 0;
    int          shown_idx  = -1;
    int          errors     = 0;
    int          checks     = 0;
    bit          running    = 1'b0;
    bit          loaded     = 1'b0;
    logic [15:0] lfsr_state = 16'd58407;

    rom_loader_top #(
        .ROM_ADDR_W (ROM_ADDR_W)
    ) rom_loader_top_i (
        .rx_ready     (rx_ready),
        .i_rst_n      (i_rst_n),
        .i_byte_valid (i_byte_valid),
        .i_byte       (i_byte),
        .o_byte_ready (o_byte_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_kind  (o_resp_kind),
        .o_resp_data  (o_resp_data),
        .i_resp_ready (i_resp_ready)
    );

    initial begin
        rx_ready = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) rx_ready = ~rx_ready;
        end
    end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic random_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    task automatic check_flag(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_read_byte(input resp_kind_e kind, input logic [7:0] data,
                                   input logic [7:0] expected);
        checks++;
        if (kind !== RESP_READ) begin
            $display("Response %0d is a checksum where a read byte was expected", resp_cnt);
            errors++;
        end else if (data !== expected) begin
            $display("Mismatch o_resp_data: got 0x%02h, expected 0x%02h", data, expected);
            errors++;
        end
    endtask

    task automatic check_checksum(input resp_kind_e kind, input logic [7:0] data,
                                  input logic [7:0] expected);
        checks++;
        if (kind !== RESP_SUM) begin
            $display("Response %0d is a read byte where a checksum was expected", resp_cnt);
            errors++;
        end else if (data !== expected) begin
            $display("Mismatch o_resp_data: got 0x%02h, expected 0x%02h", data, expected);
            errors++;
        end
    endtask

    // Keyword tokens switch the mode and hex tokens go to the queues
    task automatic load_stimulus(output bit ok);
        int    fd;
        int    rc;
        int    value;
        string tok;
        string rest;
        string mode;
        ok   = 1'b1;
        mode = "";
        fd   = $fopen("rom_loader_stimulus.txt", "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    rc = $fgets(rest, fd);
                end else if (tok == "test") begin
                    rc = $fscanf(fd, "%s", tok);
                    if (rc != 1) begin
                        ok = 1'b0;
                    end
                    test_names.push_back(tok);
                    test_bytes.push_back(0);
                    test_exps.push_back(0);
                end else if (tok == "send" || tok == "read" || tok == "sum") begin
                    mode = tok;
                end else if ($sscanf(tok, "%h", value) != 1 || test_names.size() == 0) begin
                    ok = 1'b0;
                end else if (mode == "send") begin
                    byte_q.push_back(value[7:0]);
                    test_bytes[test_bytes.size() - 1] += 1;
                end else begin
                    exp_kind_q.push_back(mode == "sum" ? RESP_SUM : RESP_READ);
                    exp_data_q.push_back(value[7:0]);
                    test_exps[test_exps.size() - 1] += 1;
                end
            end
            $fclose(fd);
            if (test_names.size() == 0) begin
                ok = 1'b0;
            end
        end
    endtask

    // Byte and response handshakes as the DUT sees them
    always @(posedge rx_ready) begin
        if (i_rst_n) begin
            if (i_byte_valid && o_byte_ready) begin
                sent_cnt++;
            end
            if (o_resp_valid && i_resp_ready) begin
                if (resp_cnt >= exp_kind_q.size()) begin
                    $display("Response 0x%02h arrived with nothing left to expect", o_resp_data);
                    errors++;
                end else if (exp_kind_q[resp_cnt] == RESP_READ) begin
                    check_read_byte(o_resp_kind, o_resp_data, exp_data_q[resp_cnt]);
                end else begin
                    check_checksum(o_resp_kind, o_resp_data, exp_data_q[resp_cnt]);
                end
                resp_cnt++;
            end
        end
    end

    // Bytes, idle gaps and back-pressure change on the falling edge
    always @(negedge rx_ready) begin
        logic gap;
        if (running) begin
            i_resp_ready = random_bit();
            // A shown byte stays until taken
            if (!i_byte_valid || sent_cnt != shown_idx) begin
                if (sent_cnt < byte_limit) begin
                    // Idle one cycle in four
                    gap = random_bit() & random_bit();
                    if (gap) begin
                        i_byte_valid = 1'b0;
                    end else begin
                        shown_idx    = sent_cnt;
                        i_byte_valid = 1'b1;
                        i_byte       = byte_q[sent_cnt];
                    end
                end else begin
                    i_byte_valid = 1'b0;
                end
            end
        end
    end

    task automatic run_tests();
        int t;
        int exp_limit;
        int err_start;
        exp_limit = 0;
        repeat (RESET_CYCLES) @(negedge rx_ready);
        i_rst_n = 1'b1;
        @(negedge rx_ready);
        // Idle state straight out of reset
        check_flag("o_resp_valid", o_resp_valid, 1'b0);
        check_flag("o_byte_ready", o_byte_ready, 1'b1);
        @(posedge rx_ready);
        running = 1'b1;
        for (t = 0; t < test_names.size(); t++) begin
            err_start  = errors;
            byte_limit = byte_limit + test_bytes[t];
            exp_limit  = exp_limit + test_exps[t];
            wait (sent_cnt == byte_limit && resp_cnt == exp_limit);
            $display("Test %s: %0d bytes, %0d responses, %0d errors",
                     test_names[t], test_bytes[t], test_exps[t], errors - err_start);
        end
        // Room for any stray response
        repeat (20) @(posedge rx_ready);
    endtask

    initial begin
        bit ok;
        i_rst_n      = 1'b0;
        i_byte_valid = 1'b0;
        i_byte       = 8'h00;
        i_resp_ready = 1'b0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Stimulus file is missing or could not be parsed");
            $display("Checks failed");
            $finish;
        end else begin
            loaded = 1'b1;
            run_tests();
            $display("%0d tests, %0d checks, %0d errors", test_names.size(), checks, errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // Budget scales with the file length
    initial begin
        int limit;
        wait (loaded);
        limit = RESET_CYCLES + 40 + CYCLES_PER_ITEM * (byte_q.size() + exp_kind_q.size());
        repeat (limit) @(posedge rx_ready);
        $display("Timeout after %0d cycles, the DUT stopped responding", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rom_loader_stimulus.txt */
# test <name> opens a group; send lists bytes to drive, in hex
# read lists expected read bytes, sum lists expected checksums, in hex
test reset_sum
send c0
sum 00
test load_read
send 03 11 22 33 44 40 00 00 83
read 11 22 33 44
test wrap_at_top
send 40 3f fe 03 a1 b2 c3 d4 40 3f fe 83 40 00 00 80
read a1 b2 c3 d4 c3
test checksum
send c0 c7
sum 94 00
test full_load
send 40 01 00 3f
send 13 18 1d 22 27 2c 31 36 3b 40 45 4a 4f 54 59 5e
send 63 68 6d 72 77 7c 81 86 8b 90 95 9a 9f a4 a9 ae
send b3 b8 bd c2 c7 cc d1 d6 db e0 e5 ea ef f4 f9 fe
send 03 08 0d 12 17 1c 21 26 2b 30 35 3a 3f 44 49 4e
send 40 01 00 bf
read 13 18 1d 22 27 2c 31 36 3b 40 45 4a 4f 54 59 5e
read 63 68 6d 72 77 7c 81 86 8b 90 95 9a 9f a4 a9 ae
read b3 b8 bd c2 c7 cc d1 d6 db e0 e5 ea ef f4 f9 fe
read 03 08 0d 12 17 1c 21 26 2b 30 35 3a 3f 44 49 4e
test read64_backpressure
send 40 01 00 bf c0
read 13 18 1d 22 27 2c 31 36 3b 40 45 4a 4f 54 59 5e
read 63 68 6d 72 77 7c 81 86 8b 90 95 9a 9f a4 a9 ae
read b3 b8 bd c2 c7 cc d1 d6 db e0 e5 ea ef f4 f9 fe
read 03 08 0d 12 17 1c 21 26 2b 30 35 3a 3f 44 49 4e
sum 20

/* all.f */
loader_pkg.sv
rom_loader_decode.sv
rom_loader_execute.sv
rom_loader_result.sv
rom_loader_top.sv
rom_loader_tb.sv

/* Bender.yml */
package:
  name: rom_loader

sources:
  - loader_pkg.sv
  - rom_loader_decode.sv
  - rom_loader_execute.sv
  - rom_loader_result.sv
  - rom_loader_top.sv
  - target: test
    files:
      - rom_loader_tb.sv
